//--- dec.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module dec (
    input        [    `INST_LEN - 1:0] inst_i,
    input                              inst_valid_i,
    output rv_isa_pkg::dec_ctrl_t      ctrl_o,
    output logic [`REG_ADDR_LEN - 1:0] rs1_addr_o,
    output logic [`REG_ADDR_LEN - 1:0] rs2_addr_o,
    output logic                       ill_inst_o
);

rv_isa_pkg::inst_r_t inst_f;
logic                f7_zero;
logic                f7_alt;
logic                ill;

assign inst_f     = inst_i;
assign f7_zero    = (inst_f.funct7 == '0);
assign f7_alt     = (inst_f.funct7 == 7'b0100000);
assign rs1_addr_o = inst_f.rs1;
assign rs2_addr_o = inst_f.rs2;
assign ill_inst_o = inst_valid_i && ill;

always_comb begin
    ctrl_o         = '0;
    ctrl_o.rd_addr = inst_f.rd;
    ill            = 1'b0;

    // Base operation from funct3, bit 30 picks the arithmetic shift
    case (inst_f.funct3)
        rv_isa_pkg::F3_ADD  : ctrl_o.alu_op = rv_isa_pkg::ADD;
        rv_isa_pkg::F3_SLL  : ctrl_o.alu_op = rv_isa_pkg::SLL;
        rv_isa_pkg::F3_SLT  : ctrl_o.alu_op = rv_isa_pkg::SLT;
        rv_isa_pkg::F3_SLTU : ctrl_o.alu_op = rv_isa_pkg::SLTU;
        rv_isa_pkg::F3_XOR  : ctrl_o.alu_op = rv_isa_pkg::XOR;
        rv_isa_pkg::F3_SRL  : ctrl_o.alu_op = inst_f.funct7[5] ? rv_isa_pkg::SRA
                                                               : rv_isa_pkg::SRL;
        rv_isa_pkg::F3_OR   : ctrl_o.alu_op = rv_isa_pkg::OR;
        default             : ctrl_o.alu_op = rv_isa_pkg::AND;
    endcase

    case (inst_f.opcode)
        rv_isa_pkg::OP: begin
            ctrl_o.rs1_rd = 1'b1;
            ctrl_o.rs2_rd = 1'b1;
            ctrl_o.rd_wr  = 1'b1;
            if (inst_f.funct3 == rv_isa_pkg::F3_ADD && inst_f.funct7[5]) begin
                ctrl_o.alu_op = rv_isa_pkg::SUB;
            end
            // Only SUB and SRA may use the alternate funct7
            ill = !(f7_zero || (f7_alt && (inst_f.funct3 == rv_isa_pkg::F3_ADD ||
                                           inst_f.funct3 == rv_isa_pkg::F3_SRL)));
        end
        rv_isa_pkg::OP_IMM: begin
            ctrl_o.rs1_rd      = 1'b1;
            ctrl_o.rs2_imm_sel = 1'b1;
            ctrl_o.rd_wr       = 1'b1;
            ctrl_o.imm         = {{(`XLEN - 12){inst_i[31]}}, inst_i[31:20]};
            if (inst_f.funct3 == rv_isa_pkg::F3_SLL) begin
                ill = !f7_zero;
            end else if (inst_f.funct3 == rv_isa_pkg::F3_SRL) begin
                ill = !(f7_zero || f7_alt);
            end
        end
        rv_isa_pkg::LUI: begin
            ctrl_o.alu_op      = rv_isa_pkg::PASS_B;
            ctrl_o.rs2_imm_sel = 1'b1;
            ctrl_o.rd_wr       = 1'b1;
            ctrl_o.imm         = {inst_i[31:12], 12'b0};
        end
        rv_isa_pkg::AUIPC: begin
            ctrl_o.alu_op      = rv_isa_pkg::ADD;
            ctrl_o.pc_sel      = 1'b1;
            ctrl_o.rs2_imm_sel = 1'b1;
            ctrl_o.rd_wr       = 1'b1;
            ctrl_o.imm         = {inst_i[31:12], 12'b0};
        end
        default: begin
            ill = 1'b1;
        end
    endcase

    if (inst_valid_i && ill) begin
        ctrl_o.rd_wr = 1'b0;
    end
end

endmodule

//--- exu.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module exu (
    input                         clk,
    input                         rst_n_i,
    input  rv_pipe_pkg::id_ex_t   id_ex_i,
    output rv_pipe_pkg::wb_result_t res_o
);

rv_pipe_pkg::wb_result_t res_d;
logic                    res_wr_ok;
logic                    fwd_rs1;
logic                    fwd_rs2;
logic [   `XLEN - 1:0]   rs1_val;
logic [   `XLEN - 1:0]   rs2_val;
logic [   `XLEN - 1:0]   op_a;
logic [   `XLEN - 1:0]   op_b;
logic [           4:0]   shamt;
logic [   `XLEN - 1:0]   alu_out;

// Forward from the instruction one ahead, never for x0
assign res_wr_ok = res_o.valid && !res_o.ill && res_o.rd_wr && (res_o.rd_addr != '0);
assign fwd_rs1   = res_wr_ok && id_ex_i.ctrl.rs1_rd && (res_o.rd_addr == id_ex_i.rs1_addr);
assign fwd_rs2   = res_wr_ok && id_ex_i.ctrl.rs2_rd && (res_o.rd_addr == id_ex_i.rs2_addr);
assign rs1_val   = fwd_rs1 ? res_o.data : id_ex_i.rs1_data;
assign rs2_val   = fwd_rs2 ? res_o.data : id_ex_i.rs2_data;

assign op_a  = id_ex_i.ctrl.pc_sel ? id_ex_i.pc : rs1_val;
assign op_b  = id_ex_i.ctrl.rs2_imm_sel ? id_ex_i.ctrl.imm : rs2_val;
assign shamt = op_b[4:0];

always_comb begin
    case (id_ex_i.ctrl.alu_op)
        rv_isa_pkg::ADD    : alu_out = op_a + op_b;
        rv_isa_pkg::SUB    : alu_out = op_a - op_b;
        rv_isa_pkg::SLL    : alu_out = op_a << shamt;
        rv_isa_pkg::SLT    : alu_out = {{(`XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
        rv_isa_pkg::SLTU   : alu_out = {{(`XLEN - 1){1'b0}}, op_a < op_b};
        rv_isa_pkg::XOR    : alu_out = op_a ^ op_b;
        rv_isa_pkg::SRL    : alu_out = op_a >> shamt;
        rv_isa_pkg::SRA    : alu_out = $signed(op_a) >>> shamt;
        rv_isa_pkg::OR     : alu_out = op_a | op_b;
        rv_isa_pkg::AND    : alu_out = op_a & op_b;
        rv_isa_pkg::PASS_B : alu_out = op_b;
        default            : alu_out = '0;
    endcase
end

always_comb begin
    res_d.valid   = id_ex_i.valid;
    res_d.ill     = id_ex_i.ill;
    res_d.rd_wr   = id_ex_i.ctrl.rd_wr;
    res_d.rd_addr = id_ex_i.ctrl.rd_addr;
    res_d.data    = alu_out;
end

always_ff @(posedge clk) begin
    if (!rst_n_i) begin
        res_o.valid <= 1'b0;
    end else if (id_ex_i.valid) begin
        res_o <= res_d;
    end else begin
        res_o.valid <= 1'b0;
    end
end

// Decoder only emits known ALU codes
assert property (@(posedge clk) disable iff (!rst_n_i)
    id_ex_i.valid |-> (id_ex_i.ctrl.alu_op <= rv_isa_pkg::PASS_B));

endmodule

//--- idu.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module idu (
    input                              clk,
    input                              rst_n_i,
    input        [    `INST_LEN - 1:0] inst_i,
    input                              inst_valid_i,
    input        [      `PC_LEN - 1:0] pc_i,
    input                              halted_i,
    input  rv_pipe_pkg::rf_wr_t        rf_wr_i,
    input        [`DBG_ADDR_LEN - 1:0] dbg_addr_i,
    input        [        `XLEN - 1:0] dbg_wdata_i,
    input                              dbg_gpr_rd_i,
    input                              dbg_gpr_wr_i,
    output logic [        `XLEN - 1:0] dbg_gpr_out_o,
    output rv_pipe_pkg::id_ex_t        id_ex_o
);

rv_isa_pkg::dec_ctrl_t      ctrl;
rv_pipe_pkg::id_ex_t        id_ex_d;
logic [`REG_ADDR_LEN - 1:0] rs1_addr;
logic [`REG_ADDR_LEN - 1:0] rs2_addr;
logic [        `XLEN - 1:0] rs1_data;
logic [        `XLEN - 1:0] rs2_data;
logic                       ill_inst;

dec u_dec (
    .inst_i       ( inst_i       ),
    .inst_valid_i ( inst_valid_i ),
    .ctrl_o       ( ctrl         ),
    .rs1_addr_o   ( rs1_addr     ),
    .rs2_addr_o   ( rs2_addr     ),
    .ill_inst_o   ( ill_inst     )
);

rfu u_rfu (
    .clk           ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .rs1_addr_i    ( rs1_addr      ),
    .rs2_addr_i    ( rs2_addr      ),
    .rs1_data_o    ( rs1_data      ),
    .rs2_data_o    ( rs2_data      ),
    .wr_i          ( rf_wr_i       ),
    .halted_i      ( halted_i      ),
    .dbg_addr_i    ( dbg_addr_i    ),
    .dbg_wdata_i   ( dbg_wdata_i   ),
    .dbg_gpr_rd_i  ( dbg_gpr_rd_i  ),
    .dbg_gpr_wr_i  ( dbg_gpr_wr_i  ),
    .dbg_gpr_out_o ( dbg_gpr_out_o )
);

always_comb begin
    id_ex_d.valid    = inst_valid_i;
    id_ex_d.ill      = ill_inst;
    id_ex_d.pc       = pc_i;
    id_ex_d.rs1_addr = rs1_addr;
    id_ex_d.rs2_addr = rs2_addr;
    id_ex_d.rs1_data = rs1_data;
    id_ex_d.rs2_data = rs2_data;
    id_ex_d.ctrl     = ctrl;
end

always_ff @(posedge clk) begin
    if (!rst_n_i) begin
        id_ex_o.valid <= 1'b0;
    end else if (inst_valid_i) begin
        id_ex_o <= id_ex_d;
    end else begin
        id_ex_o.valid <= 1'b0;
    end
end

// No issue while the debugger owns the core
assert property (@(posedge clk) disable iff (!rst_n_i) halted_i |-> !inst_valid_i);

endmodule

//--- rfu.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rfu (
    input                              clk,
    input                              rst_n_i,
    input        [`REG_ADDR_LEN - 1:0] rs1_addr_i,
    input        [`REG_ADDR_LEN - 1:0] rs2_addr_i,
    output logic [        `XLEN - 1:0] rs1_data_o,
    output logic [        `XLEN - 1:0] rs2_data_o,
    input  rv_pipe_pkg::rf_wr_t        wr_i,
    input                              halted_i,
    input        [`DBG_ADDR_LEN - 1:0] dbg_addr_i,
    input        [        `XLEN - 1:0] dbg_wdata_i,
    input                              dbg_gpr_rd_i,
    input                              dbg_gpr_wr_i,
    output logic [        `XLEN - 1:0] dbg_gpr_out_o
);

logic [        `XLEN - 1:0] gpr [1:`REG_NUM - 1];
logic [`REG_ADDR_LEN - 1:0] dbg_idx;
logic                       pipe_wr;
logic                       dbg_wr;

assign dbg_idx = dbg_addr_i[`REG_ADDR_LEN - 1:0];
assign pipe_wr = wr_i.en && (wr_i.addr != '0);
assign dbg_wr  = halted_i && dbg_gpr_wr_i && (dbg_idx != '0);

always_ff @(posedge clk) begin
    if (!rst_n_i) begin
        for (int i = 1; i < `REG_NUM; i++) begin
            gpr[i] <= '0;
        end
    end else if (pipe_wr) begin
        gpr[wr_i.addr] <= wr_i.data;
    end else if (dbg_wr) begin
        gpr[dbg_idx] <= dbg_wdata_i;
    end
end

// x0 reads zero, a same-cycle write is bypassed to the reader
always_comb begin
    if (rs1_addr_i == '0) begin
        rs1_data_o = '0;
    end else if (pipe_wr && wr_i.addr == rs1_addr_i) begin
        rs1_data_o = wr_i.data;
    end else begin
        rs1_data_o = gpr[rs1_addr_i];
    end

    if (rs2_addr_i == '0) begin
        rs2_data_o = '0;
    end else if (pipe_wr && wr_i.addr == rs2_addr_i) begin
        rs2_data_o = wr_i.data;
    end else begin
        rs2_data_o = gpr[rs2_addr_i];
    end

    if (halted_i && dbg_gpr_rd_i && dbg_idx != '0) begin
        dbg_gpr_out_o = gpr[dbg_idx];
    end else begin
        dbg_gpr_out_o = '0;
    end
end

// Pipe must be drained before a debug write
assert property (@(posedge clk) disable iff (!rst_n_i)
    !(wr_i.en && halted_i && dbg_gpr_wr_i));

endmodule

//--- rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths
`define XLEN          32
`define PC_LEN        32
`define INST_LEN      32

// Register file
`define REG_NUM       32
`define REG_ADDR_LEN  5

// Debug port, low bits select a GPR
`define DBG_ADDR_LEN  12

// Instruction fields
`define OPCODE_LEN    7
`define FUNCT3_LEN    3
`define FUNCT7_LEN    7
`define ALU_OP_LEN    4

`endif

//--- rv_core.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
dec.sv
rfu.sv
idu.sv
exu.sv
wbu.sv
rv_core_top.sv
tb_rv_core.sv

//--- rv_core_tests.txt
# P <reg> <value>   debug preload while halted
# I <name> <pc> <inst> <rd> <data> <ill>   R <name> <reg> <value>   debug readback
P 1 00000005
P 2 fffffff0
P 3 80000000
P 4 0000000c
P 0 deadbeef
R rb_x1 1 00000005
R rb_x2 2 fffffff0
R rb_x3 3 80000000
R rb_x4 4 0000000c
R rb_x0_pre 0 00000000
I add 00000000 002082b3 5 fffffff5 0
I sub 00000004 40208333 6 00000015 0
I sll 00000008 004093b3 7 00005000 0
I slt 0000000c 00112433 8 00000001 0
I sltu 00000010 001134b3 9 00000000 0
I xor 00000014 0020c533 10 fffffff5 0
I srl 00000018 0041d5b3 11 00080000 0
I sra 0000001c 4041d633 12 fff80000 0
I or 00000020 0040e6b3 13 0000000d 0
I and 00000024 0040f733 14 00000004 0
I addi 00000028 fff08793 15 00000004 0
I slti 0000002c 00112813 16 00000001 0
I sltiu 00000030 fff0b893 17 00000001 0
I xori 00000034 fff14913 18 0000000f 0
I ori 00000038 0f00e993 19 000000f5 0
I andi 0000003c 7ff17a13 20 000007f0 0
I slli 00000040 00409a93 21 00000050 0
I srli 00000044 0041db13 22 08000000 0
I srai 00000048 4041db93 23 f8000000 0
I lui 0000004c 12345c37 24 12345000 0
I auipc 00000100 00001c97 25 00001100 0
I dep_addi 00000104 00700d13 26 00000007 0
I dep_add 00000108 01ad0db3 27 0000000e 0
I dep_sub 0000010c 41ad8e33 28 00000007 0
I dep_xor 00000110 01be4eb3 29 00000009 0
I addi_x0 00000114 064e8013 0 0000006d 0
I add_from_x0 00000118 01d00f33 30 00000009 0
I ill_opcode 0000011c 000002ff 5 00000000 1
I ill_f7_op 00000120 02208333 6 00000000 1
I ill_f7_slli 00000124 40409393 7 00000000 1
R rb_x5_kept 5 fffffff5
R rb_x6_kept 6 00000015
R rb_x7_kept 7 00005000
R rb_x0_post 0 00000000
R rb_x26 26 00000007
R rb_x29 29 00000009
R rb_x30 30 00000009

//--- rv_core_top.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_core_top (
    input                              clk,
    input                              rst_n_i,
    input        [    `INST_LEN - 1:0] inst_i,
    input        [      `PC_LEN - 1:0] pc_i,
    input                              inst_valid_i,
    input                              halted_i,
    input        [`DBG_ADDR_LEN - 1:0] dbg_addr_i,
    input        [        `XLEN - 1:0] dbg_wdata_i,
    input                              dbg_gpr_rd_i,
    input                              dbg_gpr_wr_i,
    output logic [        `XLEN - 1:0] dbg_gpr_out_o,
    output rv_pipe_pkg::wb_result_t    result_o
);

rv_pipe_pkg::id_ex_t     id_ex;
rv_pipe_pkg::wb_result_t ex_res;
rv_pipe_pkg::rf_wr_t     rf_wr;

idu u_idu (
    .clk           ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .inst_i        ( inst_i        ),
    .inst_valid_i  ( inst_valid_i  ),
    .pc_i          ( pc_i          ),
    .halted_i      ( halted_i      ),
    .rf_wr_i       ( rf_wr         ),
    .dbg_addr_i    ( dbg_addr_i    ),
    .dbg_wdata_i   ( dbg_wdata_i   ),
    .dbg_gpr_rd_i  ( dbg_gpr_rd_i  ),
    .dbg_gpr_wr_i  ( dbg_gpr_wr_i  ),
    .dbg_gpr_out_o ( dbg_gpr_out_o ),
    .id_ex_o       ( id_ex         )
);

exu u_exu (
    .clk     ( clk     ),
    .rst_n_i ( rst_n_i ),
    .id_ex_i ( id_ex   ),
    .res_o   ( ex_res  )
);

wbu u_wbu (
    .res_i    ( ex_res   ),
    .result_o ( result_o ),
    .rf_wr_o  ( rf_wr    )
);

endmodule

//--- rv_isa_pkg.sv
`include "rv_consts.svh"

package rv_isa_pkg;

    // Major opcodes kept in this core
    typedef enum logic [`OPCODE_LEN - 1:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [`FUNCT3_LEN - 1:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef enum logic [`ALU_OP_LEN - 1:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    // R-type field view of an instruction word
    typedef struct packed {
        logic [  `FUNCT7_LEN - 1:0] funct7;
        logic [`REG_ADDR_LEN - 1:0] rs2;
        logic [`REG_ADDR_LEN - 1:0] rs1;
        logic [  `FUNCT3_LEN - 1:0] funct3;
        logic [`REG_ADDR_LEN - 1:0] rd;
        logic [  `OPCODE_LEN - 1:0] opcode;
    } inst_r_t;

    typedef struct packed {
        alu_op_e                    alu_op;
        logic                       rs1_rd;
        logic                       rs2_rd;
        logic                       rs2_imm_sel;
        logic                       pc_sel;
        logic                       rd_wr;
        logic [`REG_ADDR_LEN - 1:0] rd_addr;
        logic [        `XLEN - 1:0] imm;
    } dec_ctrl_t;

endpackage

//--- rv_pipe_pkg.sv
`include "rv_consts.svh"

package rv_pipe_pkg;

    // Decode to execute record
    typedef struct packed {
        logic                       valid;
        logic                       ill;
        logic [      `PC_LEN - 1:0] pc;
        logic [`REG_ADDR_LEN - 1:0] rs1_addr;
        logic [`REG_ADDR_LEN - 1:0] rs2_addr;
        logic [        `XLEN - 1:0] rs1_data;
        logic [        `XLEN - 1:0] rs2_data;
        rv_isa_pkg::dec_ctrl_t      ctrl;
    } id_ex_t;

    // Execute result, also the top-level result port
    typedef struct packed {
        logic                       valid;
        logic                       ill;
        logic                       rd_wr;
        logic [`REG_ADDR_LEN - 1:0] rd_addr;
        logic [        `XLEN - 1:0] data;
    } wb_result_t;

    typedef struct packed {
        logic                       en;
        logic [`REG_ADDR_LEN - 1:0] addr;
        logic [        `XLEN - 1:0] data;
    } rf_wr_t;

endpackage

//--- tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_rv_core;

logic                       clk;
logic                       rst_n_i;
logic [    `INST_LEN - 1:0] inst_i;
logic [      `PC_LEN - 1:0] pc_i;
logic                       inst_valid_i;
logic                       halted_i;
logic [`DBG_ADDR_LEN - 1:0] dbg_addr_i;
logic [        `XLEN - 1:0] dbg_wdata_i;
logic                       dbg_gpr_rd_i;
logic                       dbg_gpr_wr_i;
logic [        `XLEN - 1:0] dbg_gpr_out_o;
rv_pipe_pkg::wb_result_t    result_o;

// Pending results in issue order
rv_pipe_pkg::wb_result_t exp_q[$];
string                   name_q[$];
int                      due_q[$];
int                      cyc;
int                      n_pass;
int                      n_fail;

rv_core_top UUT (
    .clk           ( clk           ),
    .rst_n_i       ( rst_n_i       ),
    .inst_i        ( inst_i        ),
    .pc_i          ( pc_i          ),
    .inst_valid_i  ( inst_valid_i  ),
    .halted_i      ( halted_i      ),
    .dbg_addr_i    ( dbg_addr_i    ),
    .dbg_wdata_i   ( dbg_wdata_i   ),
    .dbg_gpr_rd_i  ( dbg_gpr_rd_i  ),
    .dbg_gpr_wr_i  ( dbg_gpr_wr_i  ),
    .dbg_gpr_out_o ( dbg_gpr_out_o ),
    .result_o      ( result_o      )
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

always @(posedge clk) begin
    cyc <= cyc + 1;
end

function automatic string format_result(input rv_pipe_pkg::wb_result_t r);
    return $sformatf("valid=%0b ill=%0b rd_wr=%0b rd=%0d data=%h",
                     r.valid, r.ill, r.rd_wr, r.rd_addr, r.data);
endfunction

task automatic check_result(input string name, input rv_pipe_pkg::wb_result_t exp,
                            input rv_pipe_pkg::wb_result_t act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %s, actual %s", name, format_result(exp),
                 format_result(act));
        n_fail++;
    end else begin
        $display("[OK] %s rd=%0d data=%h ill=%0b", name, act.rd_addr, act.data, act.ill);
        n_pass++;
    end
endtask

task automatic check_gpr(input string name, input logic [`XLEN - 1:0] exp,
                         input logic [`XLEN - 1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %h, actual %h", name, exp, act);
        n_fail++;
    end else begin
        $display("[OK] %s value=%h", name, act);
        n_pass++;
    end
endtask

// Result monitor, sampled away from the rising edge
always @(negedge clk) begin
    if (rst_n_i) begin
        if (result_o.valid) begin
            if (exp_q.size() == 0) begin
                $display("Extra result on result_o for rd %0d with nothing issued",
                         result_o.rd_addr);
                n_fail++;
            end else begin
                if (due_q[0] != cyc) begin
                    $display("Result of %s came %0d cycles after issue instead of 2",
                             name_q[0], cyc - due_q[0] + 2);
                    n_fail++;
                end
                check_result(name_q[0], exp_q[0], result_o);
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                void'(due_q.pop_front());
            end
        end else if (exp_q.size() != 0 && due_q[0] <= cyc) begin
            $display("Result of %s is missing on the cycle it was due", name_q[0]);
            n_fail++;
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
            void'(due_q.pop_front());
        end
    end
end

task automatic issue_inst(input string name, input logic [`PC_LEN - 1:0] pc,
                          input logic [`INST_LEN - 1:0] inst,
                          input logic [`REG_ADDR_LEN - 1:0] rd,
                          input logic [`XLEN - 1:0] data, input logic ill);
    rv_pipe_pkg::wb_result_t exp;
    int                      gap;
    gap = $urandom % 3;
    repeat (gap) begin
        @(negedge clk);
        inst_valid_i = 1'b0;
    end
    @(negedge clk);
    inst_i       = inst;
    pc_i         = pc;
    inst_valid_i = 1'b1;
    exp.valid    = 1'b1;
    exp.ill      = ill;
    exp.rd_wr    = !ill;
    exp.rd_addr  = rd;
    exp.data     = data;
    exp_q.push_back(exp);
    name_q.push_back(name);
    due_q.push_back(cyc + 2);
endtask

task automatic drain_pipe();
    int waited;
    waited = 0;
    @(negedge clk);
    inst_valid_i = 1'b0;
    while (exp_q.size() != 0 && waited < 20) begin
        @(negedge clk);
        waited++;
    end
    if (exp_q.size() != 0) begin
        $display("Timed out after 20 cycles with %0d results still outstanding",
                 exp_q.size());
        n_fail += exp_q.size();
        exp_q.delete();
        name_q.delete();
        due_q.delete();
    end
    // Last write lands one edge after its result
    repeat (3) @(negedge clk);
endtask

task automatic enter_halt();
    if (!halted_i) begin
        drain_pipe();
        halted_i = 1'b1;
    end
endtask

task automatic leave_halt();
    if (halted_i) begin
        @(negedge clk);
        halted_i = 1'b0;
    end
endtask

task automatic debug_write(input logic [`REG_ADDR_LEN - 1:0] idx,
                           input logic [`XLEN - 1:0] val);
    @(negedge clk);
    dbg_addr_i   = `DBG_ADDR_LEN'(idx);
    dbg_wdata_i  = val;
    dbg_gpr_wr_i = 1'b1;
    @(negedge clk);
    dbg_gpr_wr_i = 1'b0;
endtask

task automatic debug_read(input string name, input logic [`REG_ADDR_LEN - 1:0] idx,
                          input logic [`XLEN - 1:0] exp);
    @(negedge clk);
    dbg_addr_i   = `DBG_ADDR_LEN'(idx);
    dbg_gpr_rd_i = 1'b1;
    @(negedge clk);
    check_gpr(name, exp, dbg_gpr_out_o);
    dbg_gpr_rd_i = 1'b0;
endtask

initial begin
    int                         fd;
    string                      kind;
    string                      name;
    string                      line;
    logic [      `PC_LEN - 1:0] pc;
    logic [    `INST_LEN - 1:0] inst;
    logic [`REG_ADDR_LEN - 1:0] rd;
    logic [        `XLEN - 1:0] val;
    logic                       ill;
    void'($urandom(32'h2750));
    cyc          = 0;
    n_pass       = 0;
    n_fail       = 0;
    rst_n_i      = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    inst_valid_i = 1'b0;
    halted_i     = 1'b0;
    dbg_addr_i   = '0;
    dbg_wdata_i  = '0;
    dbg_gpr_rd_i = 1'b0;
    dbg_gpr_wr_i = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    fd = $fopen("rv_core_tests.txt", "r");
    if (fd == 0) begin
        $display("Could not open rv_core_tests.txt");
        $display("Finished with errors");
        $finish;
    end else begin
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "P") begin
                void'($fscanf(fd, "%d %h", rd, val));
                enter_halt();
                debug_write(rd, val);
            end else if (kind == "I") begin
                void'($fscanf(fd, "%s %h %h %d %h %d", name, pc, inst, rd, val, ill));
                leave_halt();
                issue_inst(name, pc, inst, rd, val, ill);
            end else if (kind == "R") begin
                void'($fscanf(fd, "%s %d %h", name, rd, val));
                enter_halt();
                debug_read(name, rd, val);
            end else begin
                void'($fgets(line, fd));
            end
        end
        $fclose(fd);
        drain_pipe();
        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end
end

endmodule

//--- wbu.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module wbu (
    input  rv_pipe_pkg::wb_result_t res_i,
    output rv_pipe_pkg::wb_result_t result_o,
    output rv_pipe_pkg::rf_wr_t     rf_wr_o
);

logic wr_ok;

assign wr_ok = res_i.valid && !res_i.ill && res_i.rd_wr && (res_i.rd_addr != '0);

always_comb begin
    result_o = res_i;
    // Illegal results carry no data
    if (res_i.ill) begin
        result_o.data = '0;
    end
end

always_comb begin
    rf_wr_o.en   = wr_ok;
    rf_wr_o.addr = res_i.rd_addr;
    rf_wr_o.data = res_i.data;
end

endmodule
